/* Makefile */
VERILATOR   ?= verilator
TOP         ?= img_sel_tb
FILELIST    ?= img_sel.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hdl/ctl_pkg.sv */
`default_nettype none

package ctl_pkg;

    localparam int NUM_SOURCES = 3;

    // index of a pattern source.
    typedef logic [1:0] sel_t;

    // completed frames seen at the output.
    typedef logic [15:0] count_t;

endpackage

`default_nettype wire

/* hdl/img_frame_monitor.sv */
`default_nettype none

module img_frame_monitor
    import img_pkg::*, ctl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cke,
    input  img_beat_t beat,
    output count_t    frame_count,
    output sel_t      last_source,
    output logic      frame_error
);

    logic       in_frame;
    user_t      frame_user;    // user seen on the frame start.
    logic [7:0] pix_cnt;
    logic [7:0] pix_cnt_now;
    logic       take;
    logic       sof;
    logic       eof;
    logic       bad_user;

    assign take        = cke && beat.valid;
    assign sof         = beat.row_first && beat.col_first;
    assign eof         = beat.row_last && beat.col_last;
    assign pix_cnt_now = (sof ? 8'd0 : pix_cnt) + 8'(beat.de);
    assign bad_user    = in_frame && !sof && (beat.user != frame_user);

    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame    <= 1'b0;
            pix_cnt     <= '0;
            frame_count <= '0;
            last_source <= '0;
            frame_error <= 1'b0;
        end else if (take) begin
            pix_cnt <= pix_cnt_now;
            if (sof) begin
                in_frame   <= 1'b1;
                frame_user <= beat.user;
            end
            if ((sof && in_frame) || bad_user) begin
                frame_error <= 1'b1;    // restart or mixed source.
            end
            if (eof) begin
                in_frame    <= 1'b0;
                frame_count <= frame_count + 16'd1;
                last_source <= sel_t'(beat.user);
                if ((!in_frame && !sof) || pix_cnt_now != 8'(FRAME_PIXELS)) begin
                    frame_error <= 1'b1;
                end
            end
        end
    end

    // counting only ever steps up by one.
    a_count_monotonic: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && $changed(frame_count))
            |-> frame_count == count_t'($past(frame_count) + 16'd1));

endmodule

`default_nettype wire

/* hdl/img_frame_selector.sv */
`default_nettype none

module img_frame_selector
    import img_pkg::*, ctl_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cke,
    input  sel_t                         sel,
    input  img_beat_t [NUM_SOURCES-1:0]  in_beats,
    output img_beat_t                    out_beat
);

    sel_t       sel_ff0;       // sel is asynchronous to clk.
    sel_t       sel_ff1;
    sel_t       target_sel;
    sel_t       current_sel;
    logic       busy;          // a frame of current_sel is passing.
    logic       change;
    img_beat_t  sel_beat;
    logic       frame_start;
    logic       frame_end;
    logic       pass;          // beat belongs to a frame being forwarded.

    // two-flop synchronizer that cke holds like every other register.
    always_ff @(posedge clk) begin
        if (reset) begin
            sel_ff0 <= '0;
            sel_ff1 <= '0;
        end else if (cke) begin
            sel_ff0 <= sel;
            sel_ff1 <= sel_ff0;
        end
    end

    // an index with no source behind it keeps the present one.
    assign target_sel = (int'(sel_ff1) < NUM_SOURCES) ? sel_ff1 : current_sel;

    assign sel_beat    = in_beats[current_sel];
    assign frame_start = sel_beat.valid && sel_beat.row_first && sel_beat.col_first;
    assign frame_end   = out_beat.valid && out_beat.row_last && out_beat.col_last;
    assign pass        = busy || (frame_start && !change);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            change      <= 1'b0;
            current_sel <= '0;
        end else if (cke) begin
            change <= (current_sel != target_sel);

            // a start right after a switch may still be a stale beat.
            if (frame_start && !change) begin
                busy <= 1'b1;
            end else if (frame_end) begin
                busy <= 1'b0;
            end

            if (!frame_start && !busy) begin
                current_sel <= target_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_beat.row_first <= 1'b0;
            out_beat.row_last  <= 1'b0;
            out_beat.col_first <= 1'b0;
            out_beat.col_last  <= 1'b0;
            out_beat.de        <= 1'b0;
            out_beat.valid     <= 1'b0;
        end else if (cke) begin
            out_beat       <= sel_beat;    // one enabled cycle of latency.
            out_beat.valid <= sel_beat.valid && pass;    // partial frames stay hidden.
        end
    end

    a_sel_held_in_frame: assert property (@(posedge clk) disable iff (reset)
        busy |=> $stable(current_sel));

    a_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !out_beat.valid);

endmodule

`default_nettype wire

/* hdl/img_pattern_gen.sv */
`default_nettype none

module img_pattern_gen
    import img_pkg::*, ctl_pkg::*;
#(
    parameter sel_t SOURCE_ID = 2'd0
)
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cke,
    output img_beat_t beat
);

    logic       started;       // start delay has run out.
    logic [7:0] delay_cnt;
    logic       in_vblank;
    logic [3:0] vblank_cnt;
    col_t       col_cnt;       // counts active pixels and line blanking.
    row_t       row_cnt;
    logic       active;
    img_beat_t  next_beat;

    always_ff @(posedge clk) begin
        if (reset) begin
            started    <= 1'b0;
            delay_cnt  <= '0;
            in_vblank  <= 1'b0;
            vblank_cnt <= '0;
            col_cnt    <= '0;
            row_cnt    <= '0;
        end else if (cke) begin
            if (!started) begin
                if (delay_cnt == 8'(5 * SOURCE_ID)) begin
                    started <= 1'b1;
                end else begin
                    delay_cnt <= delay_cnt + 8'd1;
                end
            end else if (in_vblank) begin
                if (vblank_cnt == 4'(V_BLANK - 1)) begin
                    in_vblank  <= 1'b0;
                    vblank_cnt <= '0;
                end else begin
                    vblank_cnt <= vblank_cnt + 4'd1;
                end
            end else if (col_cnt == col_t'(LINE_CYCLES - 1)) begin
                col_cnt <= '0;
                if (row_cnt == row_t'(IMG_HEIGHT - 1)) begin
                    row_cnt   <= '0;
                    in_vblank <= 1'b1;    // last line done so the frame goes idle.
                end else begin
                    row_cnt <= row_cnt + 6'd1;
                end
            end else begin
                col_cnt <= col_cnt + 6'd1;
            end
        end
    end

    assign active = started && !in_vblank && (col_cnt < col_t'(IMG_WIDTH));

    always_comb begin
        next_beat.row_first = active && (row_cnt == '0);
        next_beat.row_last  = active && (row_cnt == row_t'(IMG_HEIGHT - 1));
        next_beat.col_first = active && (col_cnt == '0);
        next_beat.col_last  = active && (col_cnt == col_t'(IMG_WIDTH - 1));
        next_beat.de        = active;
        next_beat.user      = user_t'(SOURCE_ID);
        next_beat.data      = {4'(SOURCE_ID), row_cnt, col_cnt};
        next_beat.valid     = active;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat.row_first <= 1'b0;
            beat.row_last  <= 1'b0;
            beat.col_first <= 1'b0;
            beat.col_last  <= 1'b0;
            beat.de        <= 1'b0;
            beat.valid     <= 1'b0;
        end else if (cke) begin
            beat <= next_beat;
        end
    end

    a_col_marks_valid: assert property (@(posedge clk) disable iff (reset)
        (beat.col_first || beat.col_last) |-> beat.valid);

endmodule

`default_nettype wire

/* hdl/img_pkg.sv */
`default_nettype none

package img_pkg;

    // frame geometry in enabled clock cycles.
    localparam int IMG_WIDTH    = 8;    // active pixels per line.
    localparam int IMG_HEIGHT   = 4;    // lines per frame.
    localparam int H_BLANK      = 2;    // idle cycles after each line.
    localparam int V_BLANK      = 6;    // idle cycles after each frame.
    localparam int LINE_CYCLES  = IMG_WIDTH + H_BLANK;
    localparam int FRAME_CYCLES = LINE_CYCLES * IMG_HEIGHT + V_BLANK;
    localparam int FRAME_PIXELS = IMG_WIDTH * IMG_HEIGHT;

    // pixel layout is {source id[15:12], row[11:6], column[5:0]}.
    typedef logic [15:0] pix_t;
    typedef logic [5:0]  row_t;
    typedef logic [5:0]  col_t;

    typedef logic [1:0]  user_t;   // carries the source id.

    // one stream beat that moves when cke and valid are both high.
    typedef struct packed {
        logic  row_first;
        logic  row_last;
        logic  col_first;
        logic  col_last;
        logic  de;
        user_t user;
        pix_t  data;
        logic  valid;
    } img_beat_t;

endpackage

`default_nettype wire

/* hdl/img_sel_top.sv */
`default_nettype none

module img_sel_top
    import img_pkg::*, ctl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cke,
    input  sel_t      sel,
    output img_beat_t out_beat,
    output count_t    frame_count,
    output sel_t      last_source,
    output logic      frame_error
);

    img_beat_t [NUM_SOURCES-1:0] gen_beats;

    // each generator starts with its own phase offset.
    for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_src
        img_pattern_gen #(
            .SOURCE_ID (sel_t'(i))
        ) u_gen (
            .clk   (clk),
            .reset (reset),
            .cke   (cke),
            .beat  (gen_beats[i])
        );
    end

    img_frame_selector u_selector (
        .clk      (clk),
        .reset    (reset),
        .cke      (cke),
        .sel      (sel),
        .in_beats (gen_beats),
        .out_beat (out_beat)
    );

    img_frame_monitor u_monitor (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .beat        (out_beat),
        .frame_count (frame_count),
        .last_source (last_source),
        .frame_error (frame_error)
    );

endmodule

`default_nettype wire

/* img_sel.f */
hdl/img_pkg.sv
hdl/ctl_pkg.sv
hdl/img_pattern_gen.sv
hdl/img_frame_selector.sv
hdl/img_frame_monitor.sv
hdl/img_sel_top.sv
test/img_sel_tb.sv

/* test/img_sel_tb.sv */
`default_nettype none

module img_sel_tb
    import img_pkg::*, ctl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD      = 20;
    localparam int          DRIVE_DELAY     = 2;
    localparam int          RESET_CYCLES    = 10;
    localparam logic [31:0] SEED            = 32'h8848;
    localparam int          WAIT_LIMIT      = 2 * FRAME_CYCLES;    // enabled cycles allowed per frame.
    localparam int          SWITCH_MARGIN   = 12;
    localparam int          STALL_LIMIT     = 2 * WAIT_LIMIT;
    localparam int          RANDOM_SWITCHES = 20;

    // frame periods each test may take, summed for the watchdog.
    localparam int BUDGET_FRAMES = 1 + 8 + 10 + 10 + 64;
    localparam int MARGIN_FRAMES = 10;
    localparam int WATCHDOG_NS   = (BUDGET_FRAMES + MARGIN_FRAMES) * FRAME_CYCLES * CLK_PERIOD;

    logic      clk;
    logic      reset;
    logic      cke;
    sel_t      sel;
    img_beat_t out_beat;
    count_t    frame_count;
    sel_t      last_source;
    logic      frame_error;

    logic [31:0] rng_state;
    string       test_name;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    // frame capture at the DUT output.
    logic      cap_active;
    logic      frame_bad;
    logic      stray_seen;
    user_t     cap_user;
    int        cap_idx;
    int        frames_captured;
    user_t     last_cap_user;
    img_beat_t prev_beat;
    logic      prev_cke;

    img_sel_top DUT (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .sel         (sel),
        .out_beat    (out_beat),
        .frame_count (frame_count),
        .last_source (last_source),
        .frame_error (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // {source id[15:12], row[11:6], column[5:0]}.
    function automatic pix_t expected_pixel(input user_t src, input int row, input int col);
        return {4'(src), 6'(row), 6'(col)};
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual, output logic ok);
        ok = (actual === expected);
        assert (ok) else begin
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string text);
        assert (cond) else begin
            $display("%s: %s", test_name, text);
            test_errors++;
        end
    endtask

    task automatic clear_capture();
        cap_active      = 1'b0;
        frame_bad       = 1'b0;
        stray_seen      = 1'b0;
        cap_user        = '0;
        cap_idx         = 0;
        frames_captured = 0;
        last_cap_user   = '0;
        prev_beat       = '0;
        prev_cke        = 1'b1;
    endtask

    // checks one beat taken at the output against the raster rule.
    task automatic take_beat(input img_beat_t b);
        int         row;
        int         col;
        logic       ok_user;
        logic       ok_data;
        logic       ok_marks;
        logic [4:0] exp_marks;
        if (b.row_first && b.col_first) begin
            check_true(!cap_active, "frame start inside an unfinished frame");
            cap_active = 1'b1;
            cap_user   = b.user;
            cap_idx    = 0;
            frame_bad  = 1'b0;
            stray_seen = 1'b0;
        end
        if (!cap_active) begin
            if (!stray_seen) begin
                check_true(cap_active, "valid beat outside any frame");
                stray_seen = 1'b1;
            end
            return;
        end
        row = cap_idx / IMG_WIDTH;
        col = cap_idx % IMG_WIDTH;
        exp_marks = {row == 0, row == IMG_HEIGHT - 1, col == 0, col == IMG_WIDTH - 1, 1'b1};
        if (!frame_bad) begin    // one report per broken frame.
            check_value("user", 32'(cap_user), 32'(b.user), ok_user);
            check_value("pixel", 32'(expected_pixel(cap_user, row, col)), 32'(b.data), ok_data);
            check_value("markers", 32'(exp_marks),
                32'({b.row_first, b.row_last, b.col_first, b.col_last, b.de}), ok_marks);
            frame_bad = !(ok_user && ok_data && ok_marks);
        end
        cap_idx++;
        if ((b.row_last && b.col_last) || cap_idx == FRAME_PIXELS) begin
            check_value("pixels in frame", 32'(FRAME_PIXELS), 32'(cap_idx), ok_data);
            cap_active    = 1'b0;
            frames_captured++;
            last_cap_user = cap_user;
        end
    endtask

    // en drives cke for the cycle after this edge.
    task automatic step(input logic en);
        logic ok;
        @(posedge clk);
        #(DRIVE_DELAY);
        if (!prev_cke) begin
            check_value("held out_beat", 32'(prev_beat), 32'(out_beat), ok);
        end
        cke       = en;
        prev_cke  = en;
        prev_beat = out_beat;
        if (en && out_beat.valid === 1'b1 && !reset) begin
            take_beat(out_beat);
        end
    endtask

    task automatic apply_reset(input sel_t start_sel);
        reset = 1'b1;
        sel   = start_sel;
        repeat (RESET_CYCLES) step(1'b1);
        reset = 1'b0;
        clear_capture();
    endtask

    task automatic wait_frames(input int count, input int limit, output logic done);
        int target;
        int n;
        target = frames_captured + count;
        n = 0;
        while (frames_captured < target && n < limit) begin
            step(1'b1);
            n++;
        end
        done = frames_captured >= target;
        check_true(done, $sformatf("timed out after %0d cycles waiting for a frame", limit));
    endtask

    // monitor outputs follow the last taken beat by one enabled cycle.
    task automatic check_monitor();
        logic ok;
        step(1'b1);
        check_value("frame_count", 32'(frames_captured), 32'(frame_count), ok);
        check_value("last_source", 32'(last_cap_user), 32'(last_source), ok);
        check_value("frame_error", 32'd0, 32'(frame_error), ok);
    endtask

    task automatic check_idle();
        logic ok;
        check_value("out_beat control bits", 32'd0,
            32'({out_beat.row_first, out_beat.row_last, out_beat.col_first,
                 out_beat.col_last, out_beat.de, out_beat.valid}), ok);
        check_value("frame_count", 32'd0, 32'(frame_count), ok);
        check_value("last_source", 32'd0, 32'(last_source), ok);
        check_value("frame_error", 32'd0, 32'(frame_error), ok);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic test_reset_state();
        begin_test("reset_state");
        reset = 1'b1;
        sel   = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            step(1'b1);
            check_idle();
        end
        reset = 1'b0;
        clear_capture();
        step(1'b1);
        check_idle();
        end_test();
    endtask

    task automatic test_default_source();
        logic ok;
        logic done;
        begin_test("default_source");
        apply_reset(2'd0);
        for (int i = 0; i < 3; i++) begin
            wait_frames(1, WAIT_LIMIT, done);
            if (!done) begin
                break;
            end
            check_value("frame source", 32'd0, 32'(last_cap_user), ok);
            check_monitor();
        end
        end_test();
    endtask

    task automatic test_switch_at_boundary();
        logic done;
        logic found;
        sel_t new_src;
        int   n;
        begin_test("switch_at_boundary");
        apply_reset(2'd0);
        wait_frames(1, WAIT_LIMIT, done);
        n = 0;
        while (!(cap_active && cap_idx >= FRAME_PIXELS / 2) && n < WAIT_LIMIT) begin
            step(1'b1);
            n++;
        end
        check_true(cap_active, "no frame in progress to switch in");
        new_src = sel_t'(32'd1 + next_random() % 32'd2);
        sel     = new_src;
        n       = 0;
        found   = 1'b0;
        while (!found && n < WAIT_LIMIT + SWITCH_MARGIN) begin
            step(1'b1);
            n++;
            found = cap_active && cap_user == new_src;
        end
        check_true(found, $sformatf("no frame from source %0d after the switch", new_src));
        if (found) begin
            wait_frames(1, WAIT_LIMIT, done);
        end
        check_monitor();
        end_test();
    endtask

    task automatic test_stall();
        logic done;
        logic en;
        int   target;
        int   n;
        begin_test("stall");
        apply_reset(2'd0);
        wait_frames(1, WAIT_LIMIT, done);
        target = frames_captured + 1;
        n = 0;
        while (frames_captured < target && n < STALL_LIMIT) begin
            en = (next_random() & 32'd3) != 32'd0;    // about one cycle in four stalls.
            step(en);
            n++;
        end
        check_true(frames_captured >= target, "frame with stalls did not complete");
        check_monitor();
        end_test();
    endtask

    task automatic test_random_switching();
        logic done;
        begin_test("random_switching");
        apply_reset(2'd0);
        for (int i = 0; i < RANDOM_SWITCHES; i++) begin
            sel = sel_t'(next_random() % 32'(NUM_SOURCES));
            wait_frames(1, 3 * FRAME_CYCLES, done);
            if (!done) begin
                break;
            end
        end
        check_monitor();
        end_test();
    endtask

    initial begin
        reset        = 1'b1;
        cke          = 1'b1;
        sel          = '0;
        rng_state    = SEED;
        test_name    = "";
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        clear_capture();
        test_reset_state();
        test_default_source();
        test_switch_at_boundary();
        test_stall();
        test_random_switching();
        $display("%0d tests run, %0d passed, %0d failed",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
